// File: hdl/ball_game_pkg.sv
`default_nettype none

package ball_game_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Screen geometry of 640x480 within 800x525 total.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int h_visible = 640;         // Active pixels per line.
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_back    = 48;
    localparam int h_total   = h_visible + h_front + h_sync + h_back;

    localparam int v_visible = 480;         // Active lines per frame.
    localparam int v_front   = 10;
    localparam int v_sync    = 2;
    localparam int v_back    = 33;
    localparam int v_total   = v_visible + v_front + v_sync + v_back;

    // Coordinates and depth share one width.
    localparam int coord_w = 16;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Depth zones.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int zone_count      = 10;
    localparam int zone_depth_step = 100;   // Depth span of one zone.

    // Ball bounding-box side per zone from near to far.
    localparam int zone_size [zone_count] = '{69, 59, 51, 43, 37, 31, 25, 21, 17, 15};

    // Ring inset grows by this much per zone.
    localparam int ring_step_x = 24;
    localparam int ring_step_y = 18;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 3-bit RGB colours.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int color_w = 3;

    localparam logic [color_w-1:0] color_border    = 3'b111;  // White.
    localparam logic [color_w-1:0] color_ring      = 3'b010;  // Green.
    localparam logic [color_w-1:0] color_ball_near = 3'b110;  // Zones 0 to 4.
    localparam logic [color_w-1:0] color_ball_far  = 3'b100;  // Zones 5 to 9.
    localparam logic [color_w-1:0] color_back      = 3'b000;

    // Cycles from counter value to output colour.
    localparam int render_lat = 2;

endpackage

`default_nettype wire

// File: hdl/video_timing.sv
`timescale 1ns/100ps
`default_nettype none

module video_timing (
    input  logic                              clk,
    input  logic                              rst_n,
    output logic [ball_game_pkg::coord_w-1:0] scan_x,
    output logic [ball_game_pkg::coord_w-1:0] scan_y,
    output logic                              scan_hsync,
    output logic                              scan_vsync,
    output logic                              scan_visible
);
    import ball_game_pkg::*;

    logic x_last;   // Last pixel of a line.
    logic y_last;   // Last line of a frame.

    // Sync window bounds.
    logic [coord_w-1:0] hs_start;
    logic [coord_w-1:0] hs_end;
    logic [coord_w-1:0] vs_start;
    logic [coord_w-1:0] vs_end;

    assign x_last = (scan_x == coord_w'(h_total - 1));
    assign y_last = (scan_y == coord_w'(v_total - 1));

    assign hs_start = coord_w'(h_visible + h_front);
    assign hs_end   = coord_w'(h_visible + h_front + h_sync);
    assign vs_start = coord_w'(v_visible + v_front);
    assign vs_end   = coord_w'(v_visible + v_front + v_sync);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pixel and line counters.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_x <= '0;
        end else if (x_last) begin
            scan_x <= '0;                       // Wrap at line end.
        end else begin
            scan_x <= scan_x + 1'b1;
        end
    end

    // Line counter moves only on the horizontal wrap.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_y <= '0;
        end else if (x_last) begin
            if (y_last) begin
                scan_y <= '0;                   // New frame.
            end else begin
                scan_y <= scan_y + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Syncs and visible flag decoded from the counters.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign scan_hsync = !((scan_x >= hs_start) && (scan_x < hs_end));  // Active low.
    assign scan_vsync = !((scan_y >= vs_start) && (scan_y < vs_end));  // Active low.

    // Back porch is what remains after the sync window up to the total.
    assign scan_visible = (scan_x < coord_w'(h_total - h_back - h_sync - h_front)) &&
                          (scan_y < coord_w'(v_total - v_back - v_sync - v_front));

endmodule

`default_nettype wire

// File: hdl/ball_sprite.sv
`timescale 1ns/100ps
`default_nettype none

module ball_sprite (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [ball_game_pkg::coord_w-1:0] scan_x,
    input  logic [ball_game_pkg::coord_w-1:0] scan_y,
    input  logic [ball_game_pkg::coord_w-1:0] ball_x,
    input  logic [ball_game_pkg::coord_w-1:0] ball_y,
    input  logic [ball_game_pkg::coord_w-1:0] ball_z,
    output logic [3:0]                        zone,
    output logic                              ball_hit,
    output logic [ball_game_pkg::color_w-1:0] ball_color
);
    import ball_game_pkg::*;

    logic [6:0]         size;       // Box side for this zone.
    logic [coord_w-1:0] dx;         // Pixel offset from the box corner.
    logic [coord_w-1:0] dy;
    logic               in_box;

    logic signed [8:0]  ox;         // Doubled offset from the disc centre.
    logic signed [8:0]  oy;
    logic signed [17:0] sq_x;
    logic signed [17:0] sq_y;
    logic [18:0]        dist_sq;
    logic [13:0]        rad_sq;     // Square of the box side.
    logic               disc_hit;
    logic               near;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Depth to zone.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Walk the thresholds from far to near so the nearest match sticks.
    always_comb begin
        zone = 4'(zone_count - 1);              // Depth 900 and up.
        for (int i = zone_count - 2; i >= 0; i--) begin
            if (ball_z < coord_w'((i + 1) * zone_depth_step)) begin
                zone = 4'(i);
            end
        end
    end

    assign size = 7'(zone_size[zone]);
    assign near = (zone < 4'(zone_count / 2));  // First half of the zones.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bounding box.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Left of or above the ball wraps to a large value and fails the test.
    assign dx = scan_x - ball_x;
    assign dy = scan_y - ball_y;

    assign in_box = (dx < coord_w'(size)) && (dy < coord_w'(size));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Disc test.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 2d+1-s puts the centre in the middle of the box for odd and even sizes.
    // Only the low bits matter once the pixel is inside the box.
    assign ox = $signed({1'b0, dx[6:0], 1'b1}) - $signed({2'b00, size});
    assign oy = $signed({1'b0, dy[6:0], 1'b1}) - $signed({2'b00, size});

    assign sq_x = ox * ox;                      // At most 68*68.
    assign sq_y = oy * oy;

    assign dist_sq = {1'b0, sq_x} + {1'b0, sq_y};
    assign rad_sq  = size * size;

    assign disc_hit = in_box && (dist_sq <= {5'b0, rad_sq});

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output stage one cycle after the scan values.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ball_hit   <= 1'b0;
            ball_color <= '0;
        end else begin
            ball_hit   <= disc_hit;
            ball_color <= near ? color_ball_near : color_ball_far;
        end
    end

endmodule

`default_nettype wire

// File: hdl/court_render.sv
`timescale 1ns/100ps
`default_nettype none

module court_render (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [ball_game_pkg::coord_w-1:0] scan_x,
    input  logic [ball_game_pkg::coord_w-1:0] scan_y,
    input  logic [3:0]                        zone,
    output logic                              court_hit,
    output logic [ball_game_pkg::color_w-1:0] court_color
);
    import ball_game_pkg::*;

    logic [coord_w-1:0] x_max;      // Last visible column.
    logic [coord_w-1:0] y_max;      // Last visible row.
    logic [coord_w-1:0] ix;         // Ring inset, left and top.
    logic [coord_w-1:0] iy;
    logic [coord_w-1:0] ring_r;     // Ring right column.
    logic [coord_w-1:0] ring_b;     // Ring bottom row.

    logic border;
    logic ring_col;
    logic ring_row;
    logic ring;

    assign x_max = coord_w'(h_visible - 1);
    assign y_max = coord_w'(v_visible - 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Screen border.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign border = (scan_x == '0) || (scan_x == x_max) ||
                    (scan_y == '0) || (scan_y == y_max);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Depth ring.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Inset shrinks the rectangle toward the centre as the ball goes deeper.
    assign ix     = coord_w'(zone * ring_step_x);
    assign iy     = coord_w'(zone * ring_step_y);
    assign ring_r = x_max - ix;
    assign ring_b = y_max - iy;

    // Vertical sides.
    assign ring_col = ((scan_x == ix) || (scan_x == ring_r)) &&
                      (scan_y >= iy) && (scan_y <= ring_b);
    // Horizontal sides.
    assign ring_row = ((scan_y == iy) || (scan_y == ring_b)) &&
                      (scan_x >= ix) && (scan_x <= ring_r);

    // At zone 0 the ring would sit on the border.
    assign ring = (zone != 4'd0) && (ring_col || ring_row);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output stage.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            court_hit   <= 1'b0;
            court_color <= '0;
        end else begin
            court_hit   <= border || ring;
            court_color <= border ? color_border : color_ring;  // Border over ring.
        end
    end

endmodule

`default_nettype wire

// File: hdl/pixel_mixer.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_mixer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              ball_hit,
    input  logic                              court_hit,
    input  logic                              visible_d1,
    input  logic [ball_game_pkg::color_w-1:0] ball_color,
    input  logic [ball_game_pkg::color_w-1:0] court_color,
    output logic [ball_game_pkg::color_w-1:0] color
);
    import ball_game_pkg::*;

    logic [color_w-1:0] mix;        // Winner before blanking.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Ball wins over court and court over background.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (ball_hit) begin
            mix = ball_color;
        end else if (court_hit) begin
            mix = court_color;
        end else begin
            mix = color_back;
        end
    end

    // Blanking forces black outside the active area.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            color <= '0;
        end else if (!visible_d1) begin
            color <= '0;                        // Porch and sync.
        end else begin
            color <= mix;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ball_scene.sv
`timescale 1ns/100ps
`default_nettype none

module ball_scene (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [ball_game_pkg::coord_w-1:0] ball_x,
    input  logic [ball_game_pkg::coord_w-1:0] ball_y,
    input  logic [ball_game_pkg::coord_w-1:0] ball_z,
    output logic [ball_game_pkg::coord_w-1:0] pixel_x,
    output logic [ball_game_pkg::coord_w-1:0] pixel_y,
    output logic                              hsync,
    output logic                              vsync,
    output logic                              visible,
    output logic [ball_game_pkg::color_w-1:0] color
);
    import ball_game_pkg::*;

    logic [coord_w-1:0] scan_x;
    logic [coord_w-1:0] scan_y;
    logic               scan_hsync;
    logic               scan_vsync;
    logic               scan_visible;
    logic [3:0]         zone;               // Shared by both renderers.
    logic               ball_hit;
    logic               court_hit;
    logic [color_w-1:0] ball_color;
    logic [color_w-1:0] court_color;

    // Delay lines matching the render pipeline.
    logic [coord_w-1:0]    x_pipe [render_lat];
    logic [coord_w-1:0]    y_pipe [render_lat];
    logic [render_lat-1:0] hs_pipe;
    logic [render_lat-1:0] vs_pipe;
    logic [render_lat-1:0] vis_pipe;

    video_timing timing0 (.clk, .rst_n, .scan_x, .scan_y, .scan_hsync, .scan_vsync,
                          .scan_visible);

    ball_sprite sprite0 (.clk, .rst_n, .scan_x, .scan_y, .ball_x, .ball_y, .ball_z,
                         .zone, .ball_hit, .ball_color);

    court_render court0 (.clk, .rst_n, .scan_x, .scan_y, .zone, .court_hit, .court_color);

    pixel_mixer mixer0 (.clk, .rst_n, .ball_hit, .court_hit, .visible_d1(vis_pipe[0]),
                        .ball_color, .court_color, .color);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Align syncs and coordinates with the colour.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < render_lat; i++) begin
                x_pipe[i] <= '0;
                y_pipe[i] <= '0;
            end
            hs_pipe  <= '1;                     // Syncs idle high.
            vs_pipe  <= '1;
            vis_pipe <= '0;
        end else begin
            x_pipe[0] <= scan_x;
            y_pipe[0] <= scan_y;
            for (int i = 1; i < render_lat; i++) begin
                x_pipe[i] <= x_pipe[i-1];
                y_pipe[i] <= y_pipe[i-1];
            end
            hs_pipe  <= {hs_pipe[render_lat-2:0], scan_hsync};
            vs_pipe  <= {vs_pipe[render_lat-2:0], scan_vsync};
            vis_pipe <= {vis_pipe[render_lat-2:0], scan_visible};
        end
    end

    assign pixel_x = x_pipe[render_lat-1];
    assign pixel_y = y_pipe[render_lat-1];
    assign hsync   = hs_pipe[render_lat-1];
    assign vsync   = vs_pipe[render_lat-1];
    assign visible = vis_pipe[render_lat-1];

endmodule

`default_nettype wire

// File: include/scene_check.svh
`ifndef SCENE_CHECK_SVH
`define SCENE_CHECK_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of one rendered pixel.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Zone from depth by integer division.
function automatic int zone_of_depth(input int z);
    int zn;
    zn = z / ball_game_pkg::zone_depth_step;
    if (zn > ball_game_pkg::zone_count - 1) begin
        zn = ball_game_pkg::zone_count - 1;     // Everything far away clamps.
    end
    return zn;
endfunction

// Disc test on the ball's bounding box.
function automatic bit in_disc(input int px, input int py,
                               input int bx, input int by, input int z);
    int s;
    int dx;
    int dy;
    int ox;
    int oy;
    s  = ball_game_pkg::zone_size[zone_of_depth(z)];
    dx = px - bx;
    dy = py - by;
    if (dx < 0 || dy < 0 || dx >= s || dy >= s) begin
        return 1'b0;                            // Outside the box.
    end
    ox = 2 * dx + 1 - s;                        // Doubled offset from centre.
    oy = 2 * dy + 1 - s;
    return (ox * ox + oy * oy) <= (s * s);
endfunction

// Screen edge.
function automatic bit on_border(input int px, input int py);
    return px == 0 || px == ball_game_pkg::h_visible - 1 ||
           py == 0 || py == ball_game_pkg::v_visible - 1;
endfunction

// Depth ring outline for a zone; zone 0 has none.
function automatic bit on_ring(input int px, input int py, input int zn);
    int ix;
    int iy;
    int xr;
    int yb;
    ix = zn * ball_game_pkg::ring_step_x;
    iy = zn * ball_game_pkg::ring_step_y;
    xr = ball_game_pkg::h_visible - 1 - ix;
    yb = ball_game_pkg::v_visible - 1 - iy;
    if (zn == 0) begin
        return 1'b0;
    end
    return ((px == ix || px == xr) && py >= iy && py <= yb) ||
           ((py == iy || py == yb) && px >= ix && px <= xr);
endfunction

// Final colour after priority and blanking.
function automatic logic [2:0] pixel_color(input int px, input int py, input int bx,
                                           input int by, input int z, input bit vis);
    if (!vis) begin
        return 3'b000;
    end
    if (in_disc(px, py, bx, by, z)) begin
        return (zone_of_depth(z) < 5) ? ball_game_pkg::color_ball_near
                                      : ball_game_pkg::color_ball_far;
    end
    if (on_border(px, py)) begin
        return ball_game_pkg::color_border;
    end
    if (on_ring(px, py, zone_of_depth(z))) begin
        return ball_game_pkg::color_ring;
    end
    return ball_game_pkg::color_back;
endfunction

`endif

// File: test/ball_scene_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ball_scene_tb;
    import ball_game_pkg::*;

    localparam int clk_period  = 40;
    localparam int scene_count = 10;
    localparam int fixed_count = 8;     // The rest are random.

    logic               clk = 1'b0;
    logic               rst_n;
    logic [coord_w-1:0] ball_x;
    logic [coord_w-1:0] ball_y;
    logic [coord_w-1:0] ball_z;
    logic [coord_w-1:0] pixel_x;
    logic [coord_w-1:0] pixel_y;
    logic               hsync;
    logic               vsync;
    logic               visible;
    logic [color_w-1:0] color;

    int                 run_cycles;     // Edges since reset release.
    logic               reset_seen;
    int                 out_pos;        // Pixel index of the output set since reset.
    int                 exp_x;
    int                 exp_y;
    logic               exp_vis;
    logic               exp_hs;
    logic               exp_vs;
    logic [color_w-1:0] exp_col;

    // Corners, ring overlap and the zone edges at 99/100 and 899/900.
    int scene_x [scene_count] = '{300, 0, 632, 30, 320, 200, 0, 500, 0, 0};
    int scene_y [scene_count] = '{200, 0, 472, 100, 240, 300, 440, 50, 0, 0};
    int scene_z [scene_count] = '{0, 99, 100, 250, 450, 899, 900, 1150, 0, 0};

    `include "scene_check.svh"

    ball_scene dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .ball_x  (ball_x),
        .ball_y  (ball_y),
        .ball_z  (ball_z),
        .pixel_x (pixel_x),
        .pixel_y (pixel_y),
        .hsync   (hsync),
        .vsync   (vsync),
        .visible (visible),
        .color   (color)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
        $display("test failed");
        $fatal(1);
    endtask

    // Loads the next scene during vertical sync of the output frame.
    task automatic next_scene(input int x, input int y, input int z);
        @(posedge clk);
        while (vsync) begin
            @(posedge clk);
        end
        ball_x <= coord_w'(x);                  // Change only in blanking.
        ball_y <= coord_w'(y);
        ball_z <= coord_w'(z);
        while (!vsync) begin
            @(posedge clk);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Expected outputs.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (!rst_n) begin
            reset_seen <= 1'b1;
            run_cycles <= 0;
        end else begin
            run_cycles <= run_cycles + 1;
        end
    end

    // Counters start at 0 and the outputs trail them by the pipeline depth.
    always_comb begin
        out_pos = run_cycles - render_lat;
        exp_x   = out_pos % h_total;
        exp_y   = (out_pos / h_total) % v_total;
        exp_vis = (exp_x < h_visible) && (exp_y < v_visible);
        exp_hs  = !(exp_x >= h_visible + h_front &&
                    exp_x < h_visible + h_front + h_sync);
        exp_vs  = !(exp_y >= v_visible + v_front &&
                    exp_y < v_visible + v_front + v_sync);
        exp_col = pixel_color(exp_x, exp_y, int'(ball_x), int'(ball_y),
                              int'(ball_z), exp_vis);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reset values are black, not visible and syncs idle.
    assert property (@(posedge clk) reset_seen && run_cycles < render_lat |->
                     {color, visible, hsync, vsync} == 6'b000011)
        else report_mismatch("reset", 'h3, int'($sampled({color, visible, hsync, vsync})));

    assert property (@(posedge clk) run_cycles >= render_lat |-> int'(pixel_x) == exp_x)
        else report_mismatch("pixel_x", $sampled(exp_x), int'($sampled(pixel_x)));
    assert property (@(posedge clk) run_cycles >= render_lat |-> int'(pixel_y) == exp_y)
        else report_mismatch("pixel_y", $sampled(exp_y), int'($sampled(pixel_y)));

    assert property (@(posedge clk) run_cycles >= render_lat |-> hsync == exp_hs)
        else report_mismatch("hsync", int'($sampled(exp_hs)), int'($sampled(hsync)));
    assert property (@(posedge clk) run_cycles >= render_lat |-> vsync == exp_vs)
        else report_mismatch("vsync", int'($sampled(exp_vs)), int'($sampled(vsync)));
    assert property (@(posedge clk) run_cycles >= render_lat |-> visible == exp_vis)
        else report_mismatch("visible", int'($sampled(exp_vis)), int'($sampled(visible)));

    // Ball, border, ring, background and blanking in one compare.
    assert property (@(posedge clk) run_cycles >= render_lat |-> color == exp_col)
        else report_mismatch("color", int'($sampled(exp_col)), int'($sampled(color)));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus and watchdog.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        rst_n      = 1'b0;
        reset_seen = 1'b0;
        run_cycles = 0;
        void'($urandom(32'h9bd90dba));
        for (int i = fixed_count; i < scene_count; i++) begin
            scene_x[i] = int'($urandom % 701);
            scene_y[i] = int'($urandom % 501);
            scene_z[i] = int'($urandom % 1201);
        end
        ball_x = coord_w'(scene_x[0]);          // First frame right out of reset.
        ball_y = coord_w'(scene_y[0]);
        ball_z = coord_w'(scene_z[0]);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 1; i < scene_count; i++) begin
            next_scene(scene_x[i], scene_y[i], scene_z[i]);
        end
        // Last frame runs to its vertical sync.
        @(posedge clk);
        while (vsync) begin
            @(posedge clk);
        end
        $display("test passed");
        $finish;
    end

    initial begin
        #(longint'(scene_count + 2) * h_total * v_total * clk_period);
        $display("timeout: frames did not complete in %0d frame times", scene_count + 2);
        $display("test failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
hdl/ball_game_pkg.sv
hdl/video_timing.sv
hdl/ball_sprite.sv
hdl/court_render.sv
hdl/pixel_mixer.sv
hdl/ball_scene.sv
test/ball_scene_tb.sv

// File: Makefile
# Verilator build and run for the ball scene testbench.

VERILATOR ?= verilator
TOP       ?= ball_scene_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuild only when a source, header or the file list changes.
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# Exit status of the simulator is the pass or fail result.
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
